//--- huff_encoder.f
hw/huff_pkg.sv
hw/huff_controller.sv
hw/huff_histogram.sv
hw/huff_tree_builder.sv
hw/huff_codebook.sv
hw/huff_translation.sv
hw/huff_encoder_top.sv
testbench/huff_checker.sv
testbench/tb_huff_encoder.sv

//--- hw/huff_codebook.sv
`timescale 1ns/1ps
`default_nettype none

module huff_codebook
  import huff_pkg::*;
(
  input  logic       hwclk,
  input  logic       rst_n_i,
  input  phase_e     phase_i,
  input  len_table_t lengths_i,
  output cb_table_t  table_o,
  output logic       cb_done_o
);

  logic                busy_q;
  logic [LEN_W-1:0]    cur_len_q;
  logic [SYM_W-1:0]    sym_q;
  logic [MAX_CODE-1:0] code_q;
  logic [MAX_CODE-1:0] code_inc;
  logic [3:0]          assigned_q;
  logic [3:0]          assigned_d;
  logic [3:0]          n_nonzero;
  logic                hit;
  logic                sweep_en;
  logic                sweep_end;
  cb_table_t           table_q;

  always_comb begin
    n_nonzero = '0;
    for (int i = 0; i < NUM_SYM; i++) begin
      if (lengths_i[i] != '0) n_nonzero = n_nonzero + 4'd1;
    end
  end

  assign sweep_en   = busy_q && (phase_i == PH_CODEBOOK);
  assign hit        = (lengths_i[sym_q] == cur_len_q);
  assign code_inc   = code_q + {{(MAX_CODE-1){1'b0}}, hit};
  assign assigned_d = assigned_q + {3'b000, hit};
  assign sweep_end  = (cur_len_q == '1) && (sym_q == '1);
  // Stop as soon as every coded symbol has its entry
  assign cb_done_o  = sweep_en && ((assigned_d == n_nonzero) || sweep_end);

  always_ff @(posedge hwclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q     <= 1'b0;
      cur_len_q  <= '0;
      sym_q      <= '0;
      code_q     <= '0;
      assigned_q <= '0;
    end else begin
      busy_q <= (phase_i == PH_CODEBOOK);
      if ((phase_i == PH_CODEBOOK) && !busy_q) begin
        cur_len_q  <= LEN_W'(1);
        sym_q      <= '0;
        code_q     <= '0;
        assigned_q <= '0;
      end else if (sweep_en) begin
        assigned_q <= assigned_d;
        if (sym_q == '1) begin
          // Next length, running code doubles
          sym_q     <= '0;
          cur_len_q <= cur_len_q + LEN_W'(1);
          code_q    <= {code_inc[MAX_CODE-2:0], 1'b0};
        end else begin
          sym_q  <= sym_q + SYM_W'(1);
          code_q <= code_inc;
        end
      end
    end
  end

  always_ff @(posedge hwclk) begin
    if ((phase_i == PH_CODEBOOK) && !busy_q) begin
      table_q <= '0;
    end else if (sweep_en && hit) begin
      table_q[sym_q].len  <= cur_len_q;
      table_q[sym_q].code <= code_q;
    end
  end

  assign table_o = table_q;

endmodule

`default_nettype wire

//--- hw/huff_controller.sv
`timescale 1ns/1ps
`default_nettype none

module huff_controller
  import huff_pkg::*;
(
  input  logic   hwclk,
  input  logic   rst_n_i,
  input  logic   start_i,
  input  logic   char_valid_i,
  input  logic   last_i,
  input  logic   build_done_i,
  input  logic   cb_done_i,
  input  logic   enc_done_i,
  output phase_e phase_o,
  output logic   done_o
);

  phase_e phase_q;
  phase_e phase_d;

  always_comb begin
    phase_d = phase_q;
    unique case (phase_q)
      PH_IDLE:     if (start_i) phase_d = PH_COUNT;
      // First pass ends with the qualified final character
      PH_COUNT:    if (char_valid_i && last_i) phase_d = PH_BUILD;
      PH_BUILD:    if (build_done_i) phase_d = PH_CODEBOOK;
      PH_CODEBOOK: if (cb_done_i) phase_d = PH_ENCODE;
      PH_ENCODE:   if (enc_done_i) phase_d = PH_IDLE;
      default:     phase_d = PH_IDLE;
    endcase
  end

  always_ff @(posedge hwclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      phase_q <= PH_IDLE;
      done_o  <= 1'b0;
    end else begin
      phase_q <= phase_d;
      // One cycle pulse as the encoder falls back to idle
      done_o  <= (phase_q == PH_ENCODE) && enc_done_i;
    end
  end

  assign phase_o = phase_q;

endmodule

`default_nettype wire

//--- hw/huff_encoder_top.sv
`timescale 1ns/1ps
`default_nettype none

module huff_encoder_top
  import huff_pkg::*;
#(
  parameter int COUNT_W = 8
) (
  input  logic             hwclk,
  input  logic             rst_n_i,
  input  logic             start_i,
  input  logic             char_valid_i,
  input  logic [SYM_W-1:0] char_i,
  input  logic             last_i,
  output logic             next_char_o,
  output logic             bit_valid_o,
  output logic             bit_o,
  output logic             done_o
);

  phase_e                          phase;
  logic                            build_done;
  logic                            cb_done;
  logic                            enc_done;
  logic [NUM_SYM-1:0][COUNT_W-1:0] counts;
  len_table_t                      lengths;
  cb_table_t                       cb_table;

  huff_controller u_controller (
    .hwclk        (hwclk),
    .rst_n_i      (rst_n_i),
    .start_i      (start_i),
    .char_valid_i (char_valid_i),
    .last_i       (last_i),
    .build_done_i (build_done),
    .cb_done_i    (cb_done),
    .enc_done_i   (enc_done),
    .phase_o      (phase),
    .done_o       (done_o)
  );

  // First pass
  huff_histogram #(.COUNT_W(COUNT_W)) u_histogram (
    .hwclk        (hwclk),
    .rst_n_i      (rst_n_i),
    .phase_i      (phase),
    .char_valid_i (char_valid_i),
    .char_i       (char_i),
    .counts_o     (counts)
  );

  huff_tree_builder #(.COUNT_W(COUNT_W)) u_tree_builder (
    .hwclk        (hwclk),
    .rst_n_i      (rst_n_i),
    .phase_i      (phase),
    .counts_i     (counts),
    .lengths_o    (lengths),
    .build_done_o (build_done)
  );

  huff_codebook u_codebook (
    .hwclk     (hwclk),
    .rst_n_i   (rst_n_i),
    .phase_i   (phase),
    .lengths_i (lengths),
    .table_o   (cb_table),
    .cb_done_o (cb_done)
  );

  // Second pass, header then replayed characters
  huff_translation u_translation (
    .hwclk        (hwclk),
    .rst_n_i      (rst_n_i),
    .phase_i      (phase),
    .lengths_i    (lengths),
    .table_i      (cb_table),
    .char_valid_i (char_valid_i),
    .char_i       (char_i),
    .last_i       (last_i),
    .next_char_o  (next_char_o),
    .bit_valid_o  (bit_valid_o),
    .bit_o        (bit_o),
    .enc_done_o   (enc_done)
  );

endmodule

`default_nettype wire

//--- hw/huff_histogram.sv
`timescale 1ns/1ps
`default_nettype none

module huff_histogram
  import huff_pkg::*;
#(
  parameter int COUNT_W = 8
) (
  input  logic                            hwclk,
  input  logic                            rst_n_i,
  input  phase_e                          phase_i,
  input  logic                            char_valid_i,
  input  logic [SYM_W-1:0]                char_i,
  output logic [NUM_SYM-1:0][COUNT_W-1:0] counts_o
);

  logic [NUM_SYM-1:0][COUNT_W-1:0] counts_q;

  // Held at zero while idle, so the counters are clear
  // on the same edge that enters the count phase
  always_ff @(posedge hwclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      counts_q <= '0;
    end else if (phase_i == PH_IDLE) begin
      counts_q <= '0;
    end else if ((phase_i == PH_COUNT) && char_valid_i) begin
      counts_q[char_i] <= counts_q[char_i] + COUNT_W'(1);
    end
  end

  assign counts_o = counts_q;

endmodule

`default_nettype wire

//--- hw/huff_pkg.sv
`default_nettype none

package huff_pkg;

  // Alphabet and code geometry
  localparam int SYM_W    = 3;
  localparam int NUM_SYM  = 8;
  localparam int LEN_W    = 3;
  localparam int MAX_CODE = 7;

  // Encoder phase, walked in order by the controller
  typedef enum logic [2:0] {
    PH_IDLE,
    PH_COUNT,
    PH_BUILD,
    PH_CODEBOOK,
    PH_ENCODE
  } phase_e;

  // Code length per symbol, index 0 in the low bits
  typedef logic [NUM_SYM-1:0][LEN_W-1:0] len_table_t;

  typedef struct packed {
    logic [LEN_W-1:0]    len;
    logic [MAX_CODE-1:0] code;
  } cb_entry_t;

  typedef cb_entry_t [NUM_SYM-1:0] cb_table_t;

endpackage

`default_nettype wire

//--- hw/huff_translation.sv
`timescale 1ns/1ps
`default_nettype none

module huff_translation
  import huff_pkg::*;
(
  input  logic             hwclk,
  input  logic             rst_n_i,
  input  phase_e           phase_i,
  input  len_table_t       lengths_i,
  input  cb_table_t        table_i,
  input  logic             char_valid_i,
  input  logic [SYM_W-1:0] char_i,
  input  logic             last_i,
  output logic             next_char_o,
  output logic             bit_valid_o,
  output logic             bit_o,
  output logic             enc_done_o
);

  localparam int HDR_W  = NUM_SYM * LEN_W;
  localparam int BCNT_W = $clog2(HDR_W + 1);

  logic                busy_q;
  logic                pend_q;
  logic                last_q;
  logic [BCNT_W-1:0]   bits_q;
  logic [HDR_W-1:0]    shift_q;
  logic [HDR_W-1:0]    hdr_word;
  logic                hdr_load;
  logic                char_load;
  logic                shifting;
  logic                final_bit;
  cb_entry_t           entry;
  logic [MAX_CODE-1:0] code_aligned;

  // Symbol 0 length sits at the top so it leaves first
  always_comb begin
    hdr_word = '0;
    for (int i = 0; i < NUM_SYM; i++) begin
      hdr_word[HDR_W-1-i*LEN_W -: LEN_W] = lengths_i[i];
    end
  end

  assign entry        = table_i[char_i];
  assign code_aligned = entry.code << (MAX_CODE - entry.len);
  assign hdr_load     = (phase_i == PH_ENCODE) && !busy_q;
  assign char_load    = busy_q && (phase_i == PH_ENCODE) && pend_q && char_valid_i;
  assign shifting     = (bits_q != '0);
  assign final_bit    = (bits_q == BCNT_W'(1));
  assign bit_valid_o  = shifting;
  assign bit_o        = shift_q[HDR_W-1];

  always_ff @(posedge hwclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q      <= 1'b0;
      pend_q      <= 1'b0;
      last_q      <= 1'b0;
      bits_q      <= '0;
      next_char_o <= 1'b0;
      enc_done_o  <= 1'b0;
    end else begin
      busy_q      <= (phase_i == PH_ENCODE);
      next_char_o <= 1'b0;
      enc_done_o  <= 1'b0;
      if (phase_i != PH_ENCODE) begin
        pend_q <= 1'b0;
        last_q <= 1'b0;
        bits_q <= '0;
      end else if (!busy_q) begin
        pend_q <= 1'b0;
        last_q <= 1'b0;
        bits_q <= BCNT_W'(HDR_W);
      end else if (shifting) begin
        bits_q <= bits_q - BCNT_W'(1);
        if (final_bit && last_q) begin
          enc_done_o <= 1'b1;
        end else if (final_bit) begin
          // Ask for the next character and wait for it
          next_char_o <= 1'b1;
          pend_q      <= 1'b1;
        end
      end else if (char_load) begin
        pend_q <= 1'b0;
        last_q <= last_i;
        bits_q <= BCNT_W'(entry.len);
      end
    end
  end

  always_ff @(posedge hwclk) begin
    if (hdr_load) begin
      shift_q <= hdr_word;
    end else if (char_load) begin
      shift_q <= {code_aligned, {(HDR_W-MAX_CODE){1'b0}}};
    end else if (shifting) begin
      shift_q <= {shift_q[HDR_W-2:0], 1'b0};
    end
  end

endmodule

`default_nettype wire

//--- hw/huff_tree_builder.sv
`timescale 1ns/1ps
`default_nettype none

module huff_tree_builder
  import huff_pkg::*;
#(
  parameter int COUNT_W = 8
) (
  input  logic                            hwclk,
  input  logic                            rst_n_i,
  input  phase_e                          phase_i,
  input  logic [NUM_SYM-1:0][COUNT_W-1:0] counts_i,
  output len_table_t                      lengths_o,
  output logic                            build_done_o
);

  logic                            busy_q;
  logic [NUM_SYM-1:0][COUNT_W-1:0] cnt_q;
  logic [NUM_SYM-1:0]              vld_q;
  logic [NUM_SYM-1:0][NUM_SYM-1:0] mask_q;
  len_table_t                      len_q;
  logic [SYM_W-1:0]                least1;
  logic [SYM_W-1:0]                least2;
  logic                            l1_found;
  logic                            l2_found;
  logic [3:0]                      n_valid;
  logic [NUM_SYM-1:0]              add_mask;
  logic                            merge_en;

  // Least pair search, strict compare keeps ties on the lowest slot
  always_comb begin
    least1   = '0;
    least2   = '0;
    l1_found = 1'b0;
    l2_found = 1'b0;
    n_valid  = '0;
    for (int i = 0; i < NUM_SYM; i++) begin
      if (vld_q[i]) begin
        n_valid = n_valid + 4'd1;
        if (!l1_found || (cnt_q[i] < cnt_q[least1])) begin
          least1   = SYM_W'(i);
          l1_found = 1'b1;
        end
      end
    end
    for (int i = 0; i < NUM_SYM; i++) begin
      if (vld_q[i] && (SYM_W'(i) != least1)) begin
        if (!l2_found || (cnt_q[i] < cnt_q[least2])) begin
          least2   = SYM_W'(i);
          l2_found = 1'b1;
        end
      end
    end
  end

  // A lone symbol still gets one bit through the same increment
  assign add_mask = (l1_found ? mask_q[least1] : '0) | (l2_found ? mask_q[least2] : '0);
  assign merge_en = busy_q && (phase_i == PH_BUILD);
  assign build_done_o = merge_en && (n_valid <= 4'd2);

  // Low for the first build cycle, which loads the slots
  always_ff @(posedge hwclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
    end else begin
      busy_q <= (phase_i == PH_BUILD);
    end
  end

  always_ff @(posedge hwclk) begin
    if ((phase_i == PH_BUILD) && !busy_q) begin
      for (int i = 0; i < NUM_SYM; i++) begin
        cnt_q[i]  <= counts_i[i];
        vld_q[i]  <= (counts_i[i] != '0);
        mask_q[i] <= NUM_SYM'(1) << i;
        len_q[i]  <= '0;
      end
    end else if (merge_en) begin
      for (int j = 0; j < NUM_SYM; j++) begin
        if (add_mask[j]) len_q[j] <= len_q[j] + LEN_W'(1);
      end
      // Parent takes the least1 slot
      if (l2_found) begin
        cnt_q[least1]  <= cnt_q[least1] + cnt_q[least2];
        mask_q[least1] <= mask_q[least1] | mask_q[least2];
        vld_q[least2]  <= 1'b0;
      end
    end
  end

  assign lengths_o = len_q;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  --top-module tb_huff_encoder \
  -f huff_encoder.f \
  -Mdir obj_dir -o sim_huff_encoder

./obj_dir/sim_huff_encoder | tee sim.log

if grep -qx "Done: no errors" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

//--- testbench/huff_checker.sv
`timescale 1ns/1ps
`default_nettype none

module huff_checker
  import huff_pkg::*;
(
  input  logic             hwclk,
  input  logic             rst_n_i,
  input  logic             start_i,
  input  logic             char_valid_i,
  input  logic [SYM_W-1:0] char_i,
  input  logic             last_i,
  input  logic             next_char_i,
  input  logic             bit_valid_i,
  input  logic             bit_i,
  input  logic             done_i,
  output int               bit_errs_o,
  output int               count_errs_o,
  output int               req_errs_o,
  output int               blocks_o
);

  localparam int HDR_BITS = 24;

  int   rec_q[$];
  logic exp_q[$];
  logic req_q[$];
  logic recording = 1'b0;
  logic req_due = 1'b0;
  int   bit_idx = 0;
  int   bit_errs = 0;
  int   count_errs = 0;
  int   req_errs = 0;
  int   blocks = 0;

  // Reference Huffman and canonical code model for the recorded block
  task automatic build_expected();
    int                 cnt [NUM_SYM];
    logic [NUM_SYM-1:0] msk [NUM_SYM];
    bit                 vld [NUM_SYM];
    int                 len [NUM_SYM];
    int                 code [NUM_SYM];
    int                 nvalid;
    int                 l1;
    int                 l2;
    int                 prev_code;
    int                 prev_len;
    bit                 first;
    for (int s = 0; s < NUM_SYM; s++) begin
      cnt[s]  = 0;
      len[s]  = 0;
      code[s] = 0;
    end
    foreach (rec_q[i]) cnt[rec_q[i]]++;
    nvalid = 0;
    for (int s = 0; s < NUM_SYM; s++) begin
      vld[s] = (cnt[s] != 0);
      msk[s] = NUM_SYM'(1) << s;
      if (vld[s]) nvalid++;
    end
    // Lone symbol still needs one bit
    if (nvalid == 1) begin
      for (int s = 0; s < NUM_SYM; s++) begin
        if (vld[s]) len[s] = 1;
      end
    end
    while (nvalid > 1) begin
      l1 = -1;
      l2 = -1;
      for (int s = 0; s < NUM_SYM; s++) begin
        if (vld[s] && (l1 < 0 || cnt[s] < cnt[l1])) l1 = s;
      end
      for (int s = 0; s < NUM_SYM; s++) begin
        if (vld[s] && s != l1 && (l2 < 0 || cnt[s] < cnt[l2])) l2 = s;
      end
      for (int s = 0; s < NUM_SYM; s++) begin
        if (msk[l1][s] || msk[l2][s]) len[s]++;
      end
      cnt[l1] = cnt[l1] + cnt[l2];
      msk[l1] = msk[l1] | msk[l2];
      vld[l2] = 1'b0;
      nvalid--;
    end
    // Canonical order: length first, then symbol
    first     = 1'b1;
    prev_code = 0;
    prev_len  = 0;
    for (int l = 1; l <= 7; l++) begin
      for (int s = 0; s < NUM_SYM; s++) begin
        if (len[s] == l) begin
          code[s]   = first ? 0 : (prev_code + 1) << (l - prev_len);
          first     = 1'b0;
          prev_code = code[s];
          prev_len  = l;
        end
      end
    end
    exp_q.delete();
    req_q.delete();
    for (int s = 0; s < NUM_SYM; s++) begin
      for (int b = LEN_W - 1; b >= 0; b--) begin
        exp_q.push_back(len[s][b]);
        // First request follows the last header bit
        req_q.push_back((s == NUM_SYM - 1) && (b == 0));
      end
    end
    foreach (rec_q[i]) begin
      for (int b = len[rec_q[i]] - 1; b >= 0; b--) begin
        exp_q.push_back(code[rec_q[i]][b]);
        req_q.push_back((b == 0) && (i != rec_q.size() - 1));
      end
    end
  endtask

  // Inputs change on falling edges, so record them on rising edges
  always @(posedge hwclk) begin
    if (!rst_n_i) begin
      recording = 1'b0;
    end else if (start_i) begin
      rec_q.delete();
      recording = 1'b1;
    end else if (recording && char_valid_i) begin
      rec_q.push_back(int'(char_i));
      if (last_i) begin
        build_expected();
        recording = 1'b0;
      end
    end
  end

  always @(negedge hwclk) begin
    if (rst_n_i) begin
      // Request pulses one cycle after the last bit of a segment
      if (next_char_i !== req_due) begin
        $display("[ERROR] %0t ns: next_char_o expected %0b, got %0b (block %0d)",
                 $time, req_due, next_char_i, blocks);
        req_errs++;
      end
      req_due = 1'b0;
      if (bit_valid_i) begin
        if (bit_idx >= exp_q.size()) begin
          $display("Block %0d: bit_valid_o strobed past the end of the stream at %0t ns",
                   blocks, $time);
          bit_errs++;
        end else if (bit_i !== exp_q[bit_idx]) begin
          $display("[ERROR] %0t ns: bit_o expected %0b, got %0b (block %0d, %s bit %0d)",
                   $time, exp_q[bit_idx], bit_i, blocks,
                   (bit_idx < HDR_BITS) ? "header" : "payload", bit_idx);
          bit_errs++;
        end
        if (bit_idx < exp_q.size()) req_due = req_q[bit_idx];
        bit_idx++;
      end
      if (done_i) begin
        if (bit_idx != exp_q.size()) begin
          $display("Block %0d: the DUT sent %0d bits but the model expects %0d",
                   blocks, bit_idx, exp_q.size());
          count_errs++;
        end
        bit_idx = 0;
        blocks++;
      end
    end
  end

  assign bit_errs_o   = bit_errs;
  assign count_errs_o = count_errs;
  assign req_errs_o   = req_errs;
  assign blocks_o     = blocks;

endmodule

`default_nettype wire

//--- testbench/tb_huff_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module tb_huff_encoder
  import huff_pkg::*;
();

  localparam int NUM_BLOCKS = 8;

  logic             hwclk;
  logic             rst_n_i;
  logic             start_i;
  logic             char_valid_i;
  logic [SYM_W-1:0] char_i;
  logic             last_i;
  logic             next_char_o;
  logic             bit_valid_o;
  logic             bit_o;
  logic             done_o;

  logic [31:0]      lfsr_q;
  logic [SYM_W-1:0] blk [0:255];
  int               blk_len [NUM_BLOCKS];
  int               cycles = 0;
  int               limit = 0;
  int               bit_errs;
  int               count_errs;
  int               req_errs;
  int               blocks;

  huff_encoder_top #(.COUNT_W(8)) uut (
    .hwclk        (hwclk),
    .rst_n_i      (rst_n_i),
    .start_i      (start_i),
    .char_valid_i (char_valid_i),
    .char_i       (char_i),
    .last_i       (last_i),
    .next_char_o  (next_char_o),
    .bit_valid_o  (bit_valid_o),
    .bit_o        (bit_o),
    .done_o       (done_o)
  );

  huff_checker u_checker (
    .hwclk        (hwclk),
    .rst_n_i      (rst_n_i),
    .start_i      (start_i),
    .char_valid_i (char_valid_i),
    .char_i       (char_i),
    .last_i       (last_i),
    .next_char_i  (next_char_o),
    .bit_valid_i  (bit_valid_o),
    .bit_i        (bit_o),
    .done_i       (done_o),
    .bit_errs_o   (bit_errs),
    .count_errs_o (count_errs),
    .req_errs_o   (req_errs),
    .blocks_o     (blocks)
  );

  initial hwclk = 1'b0;
  always #5 hwclk = ~hwclk;

  always @(posedge hwclk) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display("Done: errors found");
      $finish;
    end
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output int v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = (v << 1) | int'(lfsr_q[0]);
    end
  endtask

  // Geometric spread, symbol 0 takes about half
  task automatic draw_skewed(output int v);
    int b;
    v = 0;
    draw_bits(1, b);
    while (b == 1 && v < NUM_SYM - 1) begin
      v++;
      draw_bits(1, b);
    end
  endtask

  // 0 uniform, 1 skewed, 2 single symbol, 3 one of each
  function automatic int kind_of(input int b);
    case (b)
      0, 1, 7: return 0;
      2, 3, 6: return 1;
      4:       return 2;
      default: return 3;
    endcase
  endfunction

  task automatic send_char(input logic [SYM_W-1:0] c, input bit last);
    char_valid_i = 1'b1;
    char_i       = c;
    last_i       = last;
    @(negedge hwclk);
    char_valid_i = 1'b0;
    last_i       = 1'b0;
  endtask

  task automatic send_stray();
    int r;
    draw_bits(3, r);
    send_char(SYM_W'(r), 1'b0);
  endtask

  task automatic wait_output(input bit want_done, input bit strays);
    bit seen;
    int r;
    seen = 1'b0;
    while (!seen) begin
      @(negedge hwclk);
      char_valid_i = 1'b0;
      if (want_done ? done_o : next_char_o) begin
        seen = 1'b1;
      end else if (strays && bit_valid_o) begin
        // Strobe while bits shift out, no request pending
        draw_bits(2, r);
        if (r == 0) begin
          draw_bits(3, r);
          char_valid_i = 1'b1;
          char_i       = SYM_W'(r);
        end
      end
    end
  endtask

  task automatic run_block(input int b);
    int kind;
    int n;
    int r;
    int sym;
    int off;
    bit idle;
    kind = kind_of(b);
    n    = blk_len[b];
    idle = (b % 2) == 1;
    draw_bits(3, sym);
    draw_bits(3, off);
    for (int i = 0; i < n; i++) begin
      case (kind)
        0:       draw_bits(3, r);
        1:       draw_skewed(r);
        2:       r = sym;
        default: r = (i + off) % NUM_SYM;
      endcase
      blk[i] = SYM_W'(r);
    end
    if (idle) send_stray();
    start_i = 1'b1;
    @(negedge hwclk);
    start_i = 1'b0;
    // First pass
    for (int i = 0; i < n; i++) begin
      if (idle) begin
        draw_bits(2, r);
        repeat (r) @(negedge hwclk);
      end
      send_char(blk[i], i == n - 1);
    end
    // Lands in the build phase
    if (idle) send_stray();
    // Replay, one character per request
    for (int i = 0; i < n; i++) begin
      wait_output(1'b0, idle);
      draw_bits(2, r);
      repeat (r) @(negedge hwclk);
      send_char(blk[i], i == n - 1);
    end
    wait_output(1'b1, idle);
  endtask

  initial begin
    int r;
    rst_n_i      = 1'b0;
    start_i      = 1'b0;
    char_valid_i = 1'b0;
    char_i       = '0;
    last_i       = 1'b0;
    lfsr_q       = 32'h9a3de105;
    limit        = 200 * NUM_BLOCKS;
    for (int b = 0; b < NUM_BLOCKS; b++) begin
      if (kind_of(b) == 3) begin
        blk_len[b] = NUM_SYM;
      end else begin
        draw_bits(8, r);
        blk_len[b] = 20 + r % 181;
      end
      limit = limit + blk_len[b] * 10;
    end
    repeat (3) @(negedge hwclk);
    rst_n_i = 1'b1;
    for (int b = 0; b < NUM_BLOCKS; b++) run_block(b);
    repeat (2) @(negedge hwclk);
    $display({"Blocks done: %0d of %0d, bit errors: %0d, bit count errors: %0d, ",
              "request errors: %0d"},
             blocks, NUM_BLOCKS, bit_errs, count_errs, req_errs);
    if (bit_errs == 0 && count_errs == 0 && req_errs == 0 && blocks == NUM_BLOCKS) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
